//--- verilog/lb_cfg.svh
`ifndef LB_CFG_SVH
`define LB_CFG_SVH

// Receive interfaces feeding the dispatcher
`define LB_IF_COUNT 3
// Destination cores and slots per core
`define LB_CORE_COUNT 4
`define LB_SLOT_COUNT 4

// Flow hash format
`define LB_HASH_WIDTH 32
// Lowest hash bit of the core select field
`define LB_HASH_SEL_OFFSET 14

// Receive line count and per-interface hash queue
`define LB_LINE_WIDTH 13
`define LB_QUEUE_DEPTH 4

// Drop limit after reset, 7 in the top nibble of the line count
`define LB_DROP_LIMIT_RESET ({4'd7, {(`LB_LINE_WIDTH-4){1'b0}}})
// Host readback for commands with no register behind them
`define LB_RD_DEFAULT 32'hFEFEFEFE

`endif

//--- verilog/lb_pkg.sv
`default_nettype none

`include "lb_cfg.svh"

package lb_pkg;

  // Host command opcodes in host_cmd[3:0]
  typedef enum logic [3:0] {
    OP_ENABLED = 4'd0,
    OP_INCOME  = 4'd1,
    OP_FLUSH   = 4'd2,
    OP_SLOTS   = 4'd3
  } host_op_t;

  // Interface codes reuse the core code values, target bit tells them apart
  localparam host_op_t OP_DROPS      = OP_FLUSH;
  localparam host_op_t OP_DROP_LIMIT = OP_SLOTS;

  // Command target in host_cmd[30]
  typedef enum logic {
    TGT_CORE = 1'b0,
    TGT_IF   = 1'b1
  } host_target_t;

  typedef logic [`LB_HASH_WIDTH-1:0]           hash_t;
  typedef logic [$clog2(`LB_CORE_COUNT)-1:0]   core_id_t;
  typedef logic [$clog2(`LB_IF_COUNT)-1:0]     port_id_t;
  typedef logic [$clog2(`LB_SLOT_COUNT)-1:0]   slot_tag_t;
  typedef logic [$clog2(`LB_SLOT_COUNT+1)-1:0] slot_cnt_t;
  typedef logic [`LB_CORE_COUNT-1:0]           core_mask_t;
  typedef logic [`LB_IF_COUNT-1:0]             port_mask_t;
  typedef logic [`LB_LINE_WIDTH-1:0]           line_count_t;

endpackage

`default_nettype wire

//--- verilog/lb_hash_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "lb_cfg.svh"

module lb_hash_queue
  import lb_pkg::*;
(
  input  logic  clk,
  input  logic  rst_r,
  input  hash_t push_hash,
  input  logic  push_valid,
  output logic  push_ready,
  output hash_t head_hash,
  output logic  head_valid,
  input  logic  pop
);

  localparam int DEPTH = `LB_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  hash_t                     mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                      do_push;
  logic                      do_pop;

  // Full queue holds off the interface
  assign push_ready = (count != DEPTH);
  assign head_valid = (count != 0);
  assign head_hash  = mem[rd_ptr];
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop && head_valid;

  // Storage is written only on accepted pushes
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_hash;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave occupancy unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Decision logic only retires a head it was granted
  a_pop_not_empty: assert property (@(posedge clk) disable iff (rst_r)
    pop |-> head_valid);

endmodule

`default_nettype wire

//--- verilog/lb_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "lb_cfg.svh"

module lb_port_arbiter
  import lb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_r,
  input  port_mask_t pending,
  input  port_mask_t popping,
  output logic       sel_valid,
  output port_id_t   sel_port
);

  localparam int IFS = `LB_IF_COUNT;

  port_mask_t last_grant;
  port_mask_t request;
  logic       grant_valid;
  port_id_t   grant_port;

  // Port now in its decision cycle
  always_comb begin
    last_grant = '0;
    if (sel_valid) begin
      last_grant[sel_port] = 1'b1;
    end
  end

  // Skip the port under decision and any port retiring its head
  assign request = pending & ~last_grant & ~popping;

  // Round robin search starting after the last grant
  // sel_port keeps the last grant, so it doubles as the pointer
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_port  = sel_port;
    // Walk from farthest to nearest so the nearest requester wins
    for (int k = IFS; k >= 1; k--) begin
      idx = (int'(sel_port) + k) % IFS;
      if (request[idx]) begin
        grant_valid = 1'b1;
        grant_port  = port_id_t'(idx);
      end
    end
  end

  // Grant becomes visible in the following decision cycle
  always_ff @(posedge clk) begin
    if (rst_r) begin
      sel_valid <= 1'b0;
      sel_port  <= '0;
    end else begin
      sel_valid <= grant_valid;
      sel_port  <= grant_port;
    end
  end

  // Top indexes its queue heads with sel_port, granted head still queued
  a_sel_in_range: assert property (@(posedge clk) disable iff (rst_r)
    sel_valid |-> ((sel_port < IFS) && pending[sel_port]));

endmodule

`default_nettype wire

//--- verilog/lb_slot_pool.sv
`timescale 1ns/1ps
`default_nettype none

`include "lb_cfg.svh"

module lb_slot_pool
  import lb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_r,
  input  logic       alloc,
  input  core_id_t   alloc_core,
  output slot_tag_t  alloc_tag,
  input  logic       release_valid,
  input  core_id_t   release_core,
  input  slot_tag_t  release_tag,
  input  core_mask_t flush,
  output slot_cnt_t  free_counts [`LB_CORE_COUNT],
  output core_mask_t core_has_slot
);

  localparam int CORES = `LB_CORE_COUNT;
  localparam int SLOTS = `LB_SLOT_COUNT;

  // One bit per slot, set means free
  logic [SLOTS-1:0] free_map [CORES];
  logic [SLOTS-1:0] alloc_map;

  assign alloc_map = free_map[alloc_core];

  // Lowest free slot of the requested core
  always_comb begin
    alloc_tag = '0;
    for (int s = SLOTS - 1; s >= 0; s--) begin
      if (alloc_map[s]) begin
        alloc_tag = slot_tag_t'(s);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int c = 0; c < CORES; c++) begin
        free_map[c] <= '1;
      end
    end else begin
      for (int c = 0; c < CORES; c++) begin
        // Flush hands the whole pool back to the core
        if (flush[c]) begin
          free_map[c] <= '1;
        end else begin
          if (release_valid && (release_core == core_id_t'(c))) begin
            free_map[c][release_tag] <= 1'b1;
          end
          if (alloc && (alloc_core == core_id_t'(c))) begin
            free_map[c][alloc_tag] <= 1'b0;
          end
        end
      end
    end
  end

  // Status for usability check and host readback
  for (genvar c = 0; c < CORES; c++) begin : g_status
    assign free_counts[c]   = slot_cnt_t'($countones(free_map[c]));
    assign core_has_slot[c] = |free_map[c];
  end

  // Dispatch only allocates from a core with room
  a_alloc_has_slot: assert property (@(posedge clk) disable iff (rst_r)
    alloc |-> core_has_slot[alloc_core]);

  // Cores give back only slots they were handed
  a_release_in_use: assert property (@(posedge clk) disable iff (rst_r)
    release_valid |-> !free_map[release_core][release_tag]);

endmodule

`default_nettype wire

//--- verilog/lb_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lb_cfg.svh"

module lb_host_regs
  import lb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_r,
  input  logic [31:0] host_cmd,
  input  logic [31:0] host_wr_data,
  input  logic        host_valid,
  output logic [31:0] host_rd_data,
  input  line_count_t line_count [`LB_IF_COUNT],
  input  logic        drop_event,
  input  port_id_t    drop_port,
  input  slot_cnt_t   free_counts [`LB_CORE_COUNT],
  output core_mask_t  enabled_cores,
  output core_mask_t  income_cores,
  output core_mask_t  slots_flush,
  output port_mask_t  almost_full
);

  localparam int IFS    = `LB_IF_COUNT;
  localparam int MASK_W = $bits(core_mask_t);

  logic [31:0]  wr_data_r;
  logic         wr_r;
  host_target_t tgt_r;
  host_op_t     op_r;
  core_id_t     rd_core_r;
  port_id_t     rd_port_r;
  line_count_t  line_count_r [IFS];
  line_count_t  drop_limit;
  logic [31:0]  drop_count [IFS];
  logic [31:0]  rd_next;

  ////////////////////
  // Command capture
  ////////////////////

  always_ff @(posedge clk) begin
    wr_data_r    <= host_wr_data;
    tgt_r        <= host_target_t'(host_cmd[30]);
    op_r         <= host_op_t'(host_cmd[3:0]);
    // Index field for per-core and per-interface reads
    rd_core_r    <= host_cmd[4 +: $bits(core_id_t)];
    rd_port_r    <= host_cmd[4 +: $bits(port_id_t)];
    line_count_r <= line_count;
    host_rd_data <= rd_next;
  end

  // Write applies one edge after capture
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= `LB_DROP_LIMIT_RESET;
    end else begin
      // Write bit plus scheduler bit
      wr_r        <= host_valid && host_cmd[31] && host_cmd[29];
      // Flush lasts a single cycle
      slots_flush <= '0;
      if (wr_r) begin
        if (tgt_r == TGT_CORE) begin
          case (op_r)
            OP_ENABLED: begin
              // Disabled core stops taking traffic as well
              income_cores  <= income_cores & wr_data_r[MASK_W-1:0];
              enabled_cores <= wr_data_r[MASK_W-1:0];
            end
            OP_INCOME: income_cores <= wr_data_r[MASK_W-1:0] & enabled_cores;
            OP_FLUSH:  slots_flush  <= wr_data_r[MASK_W-1:0];
            default:   ;
          endcase
        end else if (op_r == OP_DROP_LIMIT) begin
          drop_limit <= wr_data_r[`LB_LINE_WIDTH-1:0];
        end
      end
    end
  end

  ////////////////////
  // Drop status
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
      for (int i = 0; i < IFS; i++) begin
        drop_count[i] <= '0;
      end
    end else begin
      // Interface past the limit may lose packets
      for (int i = 0; i < IFS; i++) begin
        almost_full[i] <= (line_count_r[i] >= drop_limit);
      end
      if (drop_event) begin
        drop_count[drop_port] <= drop_count[drop_port] + 32'd1;
      end
    end
  end

  // Readback select, registered into host_rd_data
  always_comb begin
    rd_next = `LB_RD_DEFAULT;
    if (tgt_r == TGT_CORE) begin
      case (op_r)
        OP_ENABLED: rd_next = 32'(enabled_cores);
        OP_INCOME:  rd_next = 32'(income_cores);
        OP_SLOTS:   rd_next = 32'(free_counts[rd_core_r]);
        default:    ;
      endcase
    end else if ((op_r == OP_DROPS) && (rd_port_r < IFS)) begin
      rd_next = drop_count[rd_port_r];
    end
  end

endmodule

`default_nettype wire

//--- verilog/lb_dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lb_cfg.svh"

module lb_dispatch_top
  import lb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_r,
  input  hash_t       hash_data [`LB_IF_COUNT],
  input  port_mask_t  hash_valid,
  output port_mask_t  hash_ready,
  input  line_count_t line_count [`LB_IF_COUNT],
  output logic        dispatch_valid,
  output port_id_t    dispatch_port,
  output core_id_t    dispatch_core,
  output slot_tag_t   dispatch_tag,
  output hash_t       dispatch_hash,
  output logic        dispatch_drop,
  input  logic        release_valid,
  input  core_id_t    release_core,
  input  slot_tag_t   release_tag,
  input  logic [31:0] host_cmd,
  input  logic [31:0] host_wr_data,
  input  logic        host_valid,
  output logic [31:0] host_rd_data
);

  hash_t      q_hash [`LB_IF_COUNT];
  port_mask_t q_valid;
  port_mask_t q_pop;
  logic       sel_valid;
  port_id_t   sel_port;
  hash_t      sel_hash;
  core_id_t   dest_core;
  logic       core_usable;
  logic       alloc;
  slot_tag_t  alloc_tag;
  logic       drop_event;
  slot_cnt_t  free_counts [`LB_CORE_COUNT];
  core_mask_t core_has_slot;
  core_mask_t income_cores;
  core_mask_t slots_flush;
  port_mask_t almost_full;

  // One hash queue per receive interface
  for (genvar i = 0; i < `LB_IF_COUNT; i++) begin : g_queue
    lb_hash_queue u_queue (
      .clk        (clk),
      .rst_r      (rst_r),
      .push_hash  (hash_data[i]),
      .push_valid (hash_valid[i]),
      .push_ready (hash_ready[i]),
      .head_hash  (q_hash[i]),
      .head_valid (q_valid[i]),
      .pop        (q_pop[i])
    );
  end

  lb_port_arbiter u_arbiter (
    .clk       (clk),
    .rst_r     (rst_r),
    .pending   (q_valid),
    .popping   (q_pop),
    .sel_valid (sel_valid),
    .sel_port  (sel_port)
  );

  lb_slot_pool u_pool (
    .clk           (clk),
    .rst_r         (rst_r),
    .alloc         (alloc),
    .alloc_core    (dest_core),
    .alloc_tag     (alloc_tag),
    .release_valid (release_valid),
    .release_core  (release_core),
    .release_tag   (release_tag),
    .flush         (slots_flush),
    .free_counts   (free_counts),
    .core_has_slot (core_has_slot)
  );

  lb_host_regs u_host (
    .clk           (clk),
    .rst_r         (rst_r),
    .host_cmd      (host_cmd),
    .host_wr_data  (host_wr_data),
    .host_valid    (host_valid),
    .host_rd_data  (host_rd_data),
    .line_count    (line_count),
    .drop_event    (drop_event),
    .drop_port     (sel_port),
    .free_counts   (free_counts),
    .enabled_cores (),
    .income_cores  (income_cores),
    .slots_flush   (slots_flush),
    .almost_full   (almost_full)
  );

  ////////////////////
  // Decision cycle
  ////////////////////

  // Core picked by the hash select field of the granted head
  assign sel_hash    = q_hash[sel_port];
  assign dest_core   = sel_hash[`LB_HASH_SEL_OFFSET +: $bits(core_id_t)];
  assign core_usable = income_cores[dest_core] && core_has_slot[dest_core];

  // Allocate, drop when the line is backed up, otherwise retry later
  always_comb begin
    alloc      = 1'b0;
    drop_event = 1'b0;
    q_pop      = '0;
    if (sel_valid) begin
      if (core_usable) begin
        alloc           = 1'b1;
        q_pop[sel_port] = 1'b1;
      end else if (almost_full[sel_port]) begin
        drop_event      = 1'b1;
        q_pop[sel_port] = 1'b1;
      end
    end
  end

  // Result strobe one cycle after the decision
  always_ff @(posedge clk) begin
    if (rst_r) begin
      dispatch_valid <= 1'b0;
    end else begin
      dispatch_valid <= alloc || drop_event;
    end
  end

  always_ff @(posedge clk) begin
    dispatch_port <= sel_port;
    dispatch_core <= dest_core;
    dispatch_tag  <= alloc ? alloc_tag : '0;
    dispatch_hash <= sel_hash;
    dispatch_drop <= drop_event;
  end

endmodule

`default_nettype wire

//--- verif/lb_dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lb_cfg.svh"

module lb_dispatch_tb
  import lb_pkg::*;
();

  // Record operation codes in the top byte of each data word
  localparam logic [7:0] REC_END     = 8'h00;
  localparam logic [7:0] REC_WRITE   = 8'h01;
  localparam logic [7:0] REC_READ    = 8'h02;
  localparam logic [7:0] REC_PUSH    = 8'h03;
  localparam logic [7:0] REC_RELEASE = 8'h04;
  localparam logic [7:0] REC_LINE    = 8'h05;
  localparam logic [7:0] REC_HOLD    = 8'h06;
  localparam logic [7:0] REC_EXPECT  = 8'h07;
  localparam int MAX_RECORDS = 128;

  logic        clk;
  logic        rst_r;
  hash_t       hash_data [`LB_IF_COUNT];
  port_mask_t  hash_valid;
  port_mask_t  hash_ready;
  line_count_t line_count [`LB_IF_COUNT];
  logic        dispatch_valid;
  port_id_t    dispatch_port;
  core_id_t    dispatch_core;
  slot_tag_t   dispatch_tag;
  hash_t       dispatch_hash;
  logic        dispatch_drop;
  logic        release_valid;
  core_id_t    release_core;
  slot_tag_t   release_tag;
  logic [31:0] host_cmd;
  logic [31:0] host_wr_data;
  logic        host_valid;
  logic [31:0] host_rd_data;

  logic [95:0] records [MAX_RECORDS];
  int          n_records;
  bit          loaded;
  // Last pushed hash, compared against the dispatch fields
  hash_t       last_hash;
  port_id_t    last_port;

  lb_dispatch_top UUT (
    .clk            (clk),
    .rst_r          (rst_r),
    .hash_data      (hash_data),
    .hash_valid     (hash_valid),
    .hash_ready     (hash_ready),
    .line_count     (line_count),
    .dispatch_valid (dispatch_valid),
    .dispatch_port  (dispatch_port),
    .dispatch_core  (dispatch_core),
    .dispatch_tag   (dispatch_tag),
    .dispatch_hash  (dispatch_hash),
    .dispatch_drop  (dispatch_drop),
    .release_valid  (release_valid),
    .release_core   (release_core),
    .release_tag    (release_tag),
    .host_cmd       (host_cmd),
    .host_wr_data   (host_wr_data),
    .host_valid     (host_valid),
    .host_rd_data   (host_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, actual,
               expected);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic host_write(input logic [31:0] cmd, input logic [31:0] data);
    host_cmd     = cmd;
    host_wr_data = data;
    host_valid   = 1'b1;
    step_cycle();
    host_valid = 1'b0;
    // Capture edge, apply edge, then a flush refill
    repeat (3) step_cycle();
  endtask

  // Command held three cycles before readback is valid
  task automatic host_read(input logic [31:0] cmd, input logic [31:0] expected);
    host_cmd   = cmd;
    host_valid = 1'b0;
    repeat (3) step_cycle();
    check(host_rd_data, expected, $sformatf("host readback of command %h", cmd));
  endtask

  task automatic push_hash(input port_id_t port, input hash_t hash);
    check(32'(hash_ready[port]), 32'd1, "hash_ready high before push");
    hash_data[port]  = hash;
    hash_valid[port] = 1'b1;
    step_cycle();
    hash_valid[port] = 1'b0;
    last_hash = hash;
    last_port = port;
  endtask

  // Expected word holds drop, core and tag in its low three nibbles
  task automatic await_dispatch(input logic [31:0] expected);
    int waited;
    waited = 0;
    while (dispatch_valid !== 1'b1) begin
      if (waited == 50) begin
        $display("No dispatch arrived within 50 cycles for hash %h on port %0d",
                 last_hash, last_port);
        $display("Checks failed");
        $fatal(1);
      end
      step_cycle();
      waited++;
    end
    check(32'(dispatch_port), 32'(last_port), "dispatch port");
    check(dispatch_hash, last_hash, "dispatch hash");
    check(32'(dispatch_core), 32'(expected[7:4]), "dispatch core");
    check(32'(dispatch_tag), 32'(expected[3:0]), "dispatch tag");
    check(32'(dispatch_drop), 32'(expected[8]), "dispatch drop bit");
    // Step past the one-cycle strobe
    step_cycle();
  endtask

  // Hash must stay queued while its core has no slot
  task automatic hold_check();
    repeat (20) begin
      step_cycle();
      check(32'(dispatch_valid), 32'd0, "no dispatch while core is exhausted");
    end
  endtask

  task automatic release_slot(input core_id_t core, input slot_tag_t tag);
    release_core  = core;
    release_tag   = tag;
    release_valid = 1'b1;
    step_cycle();
    release_valid = 1'b0;
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    wait (loaded);
    repeat (n_records * 60 + 20) @(posedge clk);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks failed");
    $fatal(1);
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic [95:0] rec;
    rst_r         = 1'b1;
    hash_valid    = '0;
    release_valid = 1'b0;
    release_core  = '0;
    release_tag   = '0;
    host_cmd      = '0;
    host_wr_data  = '0;
    host_valid    = 1'b0;
    last_hash     = '0;
    last_port     = '0;
    loaded        = 1'b0;
    for (int i = 0; i < `LB_IF_COUNT; i++) begin
      hash_data[i]  = '0;
      line_count[i] = '0;
    end
    $readmemh("verif/lb_testdata.txt", records);
    // Count up to and including the end record
    n_records = 0;
    while ((n_records < MAX_RECORDS - 1) && (records[n_records][95:88] !== REC_END)) begin
      n_records++;
    end
    n_records++;
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_r = 1'b0;
    repeat (2) step_cycle();
    for (int r = 0; r < n_records; r++) begin
      rec = records[r];
      case (rec[95:88])
        REC_END:     ;
        REC_WRITE:   host_write(rec[63:32], rec[31:0]);
        REC_READ:    host_read(rec[63:32], rec[31:0]);
        REC_PUSH: begin
          push_hash(port_id_t'(rec[65:64]), rec[63:32]);
          await_dispatch(rec[31:0]);
        end
        REC_HOLD: begin
          push_hash(port_id_t'(rec[65:64]), rec[63:32]);
          hold_check();
        end
        REC_RELEASE: release_slot(core_id_t'(rec[5:4]), slot_tag_t'(rec[1:0]));
        REC_LINE: begin
          line_count[rec[65:64]] = line_count_t'(rec[31:0]);
          // Registered line count, then the almost-full flag
          repeat (3) step_cycle();
        end
        REC_EXPECT:  await_dispatch(rec[31:0]);
        default: begin
          $display("Unknown record operation %h at record %0d", rec[95:88], r);
          $display("Checks failed");
          $fatal(1);
        end
      endcase
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/lb_testdata.txt
// op(2) port(6) a(8) b(8): 01 write cmd,data  02 read cmd,expected  03 push hash,exp
// 04 release b=core,tag  05 line count b=value  06 push and hold  07 expect  00 end
02_000000_00000000_00000000 // enabled mask after reset
01_000000_A0000000_0000000B // enable cores 0, 1 and 3
02_000000_00000000_0000000B
01_000000_A0000001_0000000F // income masked by enabled
02_000000_00000001_0000000B
01_000000_A0000000_00000007 // disabling core 3 drops it from income
02_000000_00000001_00000003
01_000000_A0000000_0000000F
01_000000_A0000001_0000000F
02_000000_00000001_0000000F
02_000000_00000005_FEFEFEFE // unknown command
02_000000_00000013_00000004 // core 1 free count
03_000000_12344ABC_00000010 // core 1 tags 0 to 3
03_000001_5A5A7001_00000011
03_000002_00004000_00000012
02_000000_00000013_00000001
03_000000_FFFF4FFF_00000013
02_000000_00000013_00000000
03_000001_89AB8123_00000020 // core 2 first tag
04_000000_00000000_00000012 // release core 1 tag 2
02_000000_00000013_00000001
03_000002_0ACE5678_00000012 // reallocated lowest free
01_000000_E0000003_00000100 // drop limit
05_000001_00000000_00000100 // port 1 at the limit
03_000001_3C3C7F00_00000110 // dropped, tag zero
02_000000_40000012_00000001 // port 1 drop count
02_000000_40000002_00000000
05_000001_00000000_00000000
05_000000_00000000_000000FF // port 0 below the limit
06_000000_00007777_00000000 // waits for a core 1 slot
04_000000_00000000_00000011 // release core 1 tag 1
07_000000_00000000_00000011
01_000000_A0000002_00000002 // flush core 1
02_000000_00000013_00000004
02_000000_00000023_00000003
03_000002_12344321_00000010
00_000000_00000000_00000000

//--- vlog.f
+incdir+verilog
verilog/lb_pkg.sv
verilog/lb_hash_queue.sv
verilog/lb_port_arbiter.sv
verilog/lb_slot_pool.sv
verilog/lb_host_regs.sv
verilog/lb_dispatch_top.sv
verif/lb_dispatch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dispatcher testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module lb_dispatch_tb -Mdir obj_dir -o lb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/lb_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
